// File: ex1Stage.f
common/ex1Pkg.sv
hw/ex1AddrGen.sv
hw/ex1Decode.sv
ex1Exec/ex1Execute.sv
hw/ex1Top.sv
test/ex1Stage_assertions.sv
test/ex1Tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := ex1Tb
FILELIST  := ex1Stage.f
FLAGS     := --binary --timing --assert -j 0
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/ex1Tb.sv
// testbench for ex1Top: random and directed micro-ops against a reference model, self-checking
`timescale 1ns/1ns

module ex1Tb;
	import ex1Pkg::*;

	localparam int ADDRW       = ADDR_W_DEFAULT;
	localparam int RST_CYCLES  = 8;
	localparam int N_RAND      = 150;
	localparam int N_DIRECTED  = 60;
	localparam int NUM_OPS     = RST_CYCLES + N_RAND + N_DIRECTED;
	localparam int MAX_CYCLES  = 2 * NUM_OPS + 50;

	typedef struct packed {
		gprId_t      id;
		dataWord_t   val;
		logic        bra;
		dataWord_t   braPc;
		memOpm_t     opm;
		logic [ADDRW-1:0] addr;
		dataWord_t   data;
		logic [15:0] trap;
		logic        t;
	} expOut_t;

	logic clock = 1'b0;
	logic arstN;
	uCmd_t opUCmd;
	uIxt_t opUIxt;
	gprId_t regIdRm;
	dataWord_t regValRs, regValRt, regValRm, regValPc;
	logic opBraFlush, memHold;
	gprId_t regIdRn;
	dataWord_t regValRn, braPc, memData;
	logic braValid, srT;
	memOpm_t memOpm;
	logic [ADDRW-1:0] memAddr;
	logic [15:0] trapCode;

	logic [31:0] lfsrState = 32'd93481;
	int mismatches = 0;
	int otherFails = 0;
	int cycles = 0;
	expOut_t pipeQ[$];
	expOut_t expCur;
	expOut_t pred;
	logic modelT;

	ex1Top #(.addrW(ADDRW)) i_ex1Top (.*);

	always #20 clock = ~clock;

	// taps 32,22,2,1, one step per bit taken
	function automatic dataWord_t randBits(int n);
		dataWord_t r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	function automatic expOut_t idleOut(logic t);
		expOut_t r;
		r = '0;
		r.id = GPR_ZZR;
		r.opm = OPM_READY;
		r.trap = TRAP_NONE;
		r.t = t;
		return r;
	endfunction

	// expected outputs of one op, given T as execute will see it
	function automatic expOut_t predictOut(uCmd_t cmd, uIxt_t ixt, gprId_t rm, dataWord_t rs,
			dataWord_t rt, dataWord_t rmv, dataWord_t pc, logic flush, logic tIn);
		expOut_t r;
		logic en;
		logic [5:0] op;
		dataWord_t sum;
		int n;
		r = idleOut(tIn);
		op = cmd[5:0];
		en = (cmd[7:6] == CC_AL) || (cmd[7:6] == CC_CT && tIn) || (cmd[7:6] == CC_CF && !tIn);
		if (flush || !en)
			return r;
		sum = rs + (rt << ixt.mem.size);
		r.addr = sum[ADDRW-1:0];
		if (op > UCMD_OPIXT || op == UCMD_INVOP) begin
			r.trap = TRAP_INVOP;
		end else if (op == UCMD_LEA) begin
			r.id = rm;
			r.val = dataWord_t'(r.addr);
		end else if (op == UCMD_LOAD || op == UCMD_STORE) begin
			r.opm = {(op == UCMD_LOAD) ? 2'b01 : 2'b10, ixt.mem.sx, ixt.mem.size};
			r.data = rmv;
		end else if (op == UCMD_MOVIR) begin
			r.id = rm;
			// shift amount 0, 8, 16 or 32 bits
			n = (ixt.ctl.sub == 6'h01) ? 8 : (ixt.ctl.sub == 6'h02) ? 16 :
				(ixt.ctl.sub == 6'h03) ? 32 : 0;
			r.val = (n == 0) ? rt : ((rs << n) | (rt & ((64'd1 << n) - 1)));
		end else if (op == UCMD_BRA) begin
			r.bra = 1'b1;
			r.braPc = pc + rt * 2;
		end else if (op == UCMD_JMP) begin
			r.bra = 1'b1;
			r.braPc = {pc[63:48], rs[47:0]};
		end else if (op == UCMD_OPIXT) begin
			if (ixt.ctl.sub == IXT_CLRT) r.t = 1'b0;
			if (ixt.ctl.sub == IXT_SETT) r.t = 1'b1;
			if (ixt.ctl.sub == IXT_NOTT) r.t = !tIn;
			if (ixt.ctl.sub == IXT_TRAPA) r.trap = 16'hC080 + rm[3:0];
		end
		return r;
	endfunction

	task automatic checkWord(string name, dataWord_t got, dataWord_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkId(string name, gprId_t got, gprId_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkOpm(string name, memOpm_t got, memOpm_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkTrap(string name, logic [15:0] got, logic [15:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// model pipeline, two slots deep like the DUT
	always @(posedge clock) begin
		if (!arstN) begin
			pipeQ.delete();
			modelT = 1'b0;
			expCur = idleOut(1'b0);
		end else if (!memHold) begin
			pred = predictOut(opUCmd, opUIxt, regIdRm, regValRs, regValRt, regValRm,
				regValPc, opBraFlush, modelT);
			modelT = pred.t;
			pipeQ.push_back(pred);
			if (pipeQ.size() > 1)
				expCur = pipeQ.pop_front();
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clock) begin
		checkId("regIdRn", regIdRn, expCur.id);
		if (expCur.id != GPR_ZZR)
			checkWord("regValRn", regValRn, expCur.val);
		checkFlag("braValid", braValid, expCur.bra);
		if (expCur.bra)
			checkWord("braPc", braPc, expCur.braPc);
		checkOpm("memOpm", memOpm, expCur.opm);
		if (expCur.opm != OPM_READY)
			checkWord("memAddr", dataWord_t'(memAddr), dataWord_t'(expCur.addr));
		if (expCur.opm[4:3] == 2'b10)
			checkWord("memData", memData, expCur.data);
		checkTrap("trapCode", trapCode, expCur.trap);
		checkFlag("srT", srT, expCur.t);
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			otherFails++;
			$display("run did not finish within %0d cycles", MAX_CYCLES);
			$display("errors: %0d mismatches, %0d other failures", mismatches, otherFails);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic driveOp(logic [1:0] cond, logic [5:0] op, uIxt_t ixt, gprId_t rm,
			logic flush);
		@(posedge clock);
		opUCmd     <= {1'b0, cond, op};
		opUIxt     <= ixt;
		regIdRm    <= rm;
		regValRs   <= randBits(64);
		regValRt   <= randBits(64);
		regValRm   <= randBits(64);
		regValPc   <= randBits(64);
		opBraFlush <= flush;
		memHold    <= 1'b0;
	endtask

	// garbage on the inputs must be ignored while held
	task automatic holdFor(int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clock);
			memHold  <= 1'b1;
			opUCmd   <= uCmd_t'(randBits(9));
			regValRs <= randBits(64);
		end
	endtask

	function automatic uIxt_t subOp(logic [5:0] s);
		uIxt_t x;
		x = '0;
		x.ctl.sub = s;
		return x;
	endfunction

	initial begin
		logic [5:0] kinds[4];
		logic [5:0] op;
		uIxt_t ixt;
		kinds = '{UCMD_LEA, UCMD_STORE, UCMD_LOAD, UCMD_MOVIR};
		arstN = 1'b0;
		opUCmd = '0;
		opUIxt = '0;
		regIdRm = GPR_ZZR;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValPc = '0;
		opBraFlush = 1'b0;
		memHold = 1'b0;
		repeat (RST_CYCLES) @(posedge clock);
		arstN <= 1'b1;
		for (int i = 0; i < N_RAND; i++) begin
			op = kinds[randBits(2)];
			ixt = uIxt_t'(randBits(9));
			if (op == UCMD_MOVIR)
				ixt.ctl.sub = 6'(randBits(2));
			driveOp(2'(randBits(2)), op, ixt, gprId_t'(randBits(5)), 1'b0);
		end
		// T predication
		driveOp(CC_AL, UCMD_OPIXT, subOp(IXT_SETT), 5'd1, 1'b0);
		driveOp(CC_CT, UCMD_LEA, '0, 5'd2, 1'b0);
		driveOp(CC_CF, UCMD_LEA, '0, 5'd3, 1'b0);
		driveOp(CC_AL, UCMD_OPIXT, subOp(IXT_NOTT), 5'd1, 1'b0);
		driveOp(CC_CT, UCMD_MOVIR, subOp(IXT_LDISH8), 5'd4, 1'b0);
		driveOp(CC_CF, UCMD_MOVIR, subOp(IXT_LDISH16), 5'd5, 1'b0);
		driveOp(CC_NV, UCMD_LEA, '0, 5'd6, 1'b0);
		driveOp(CC_CF, UCMD_OPIXT, subOp(IXT_NOTT), 5'd1, 1'b0);
		driveOp(CC_CT, UCMD_MOVIR, subOp(IXT_LDISH32), 5'd7, 1'b0);
		driveOp(CC_AL, UCMD_OPIXT, subOp(IXT_CLRT), 5'd1, 1'b0);
		driveOp(CC_CT, UCMD_STORE, '0, 5'd8, 1'b0);
		driveOp(CC_CF, UCMD_LOAD, '0, 5'd9, 1'b0);
		driveOp(CC_NV, UCMD_MOVIR, '0, 5'd10, 1'b0);
		// branches
		driveOp(CC_AL, UCMD_BRA, '0, 5'd0, 1'b0);
		driveOp(CC_AL, UCMD_JMP, '0, 5'd0, 1'b0);
		driveOp(CC_CT, UCMD_BRA, '0, 5'd0, 1'b0);
		driveOp(CC_CF, UCMD_JMP, '0, 5'd0, 1'b0);
		// traps and flush
		driveOp(CC_AL, UCMD_INVOP, '0, 5'd0, 1'b0);
		driveOp(CC_AL, 6'h2A, '0, 5'd11, 1'b0);
		driveOp(CC_NV, 6'h3F, '0, 5'd11, 1'b0);
		driveOp(CC_AL, UCMD_OPIXT, subOp(IXT_TRAPA), 5'h17, 1'b0);
		driveOp(CC_AL, UCMD_OPIXT, subOp(6'h2C), 5'd3, 1'b0);
		driveOp(CC_AL, UCMD_LEA, '0, 5'd12, 1'b1);
		driveOp(CC_AL, UCMD_OPIXT, subOp(IXT_SETT), 5'd0, 1'b1);
		driveOp(CC_AL, UCMD_STORE, '0, 5'd0, 1'b1);
		// stall with two ops in flight
		driveOp(CC_AL, UCMD_LEA, '0, 5'd13, 1'b0);
		driveOp(CC_AL, UCMD_STORE, '0, 5'd14, 1'b0);
		holdFor(5);
		driveOp(CC_AL, UCMD_MOVIR, subOp(IXT_LDISH8), 5'd15, 1'b0);
		holdFor(3);
		driveOp(CC_AL, UCMD_BRA, '0, 5'd0, 1'b0);
		repeat (3)
			driveOp(CC_AL, UCMD_NOP, '0, 5'd0, 1'b0);
		@(negedge clock);
		@(negedge clock);
		$display("errors: %0d mismatches, %0d other failures", mismatches, otherFails);
		if (mismatches == 0 && otherFails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: test/ex1Stage_assertions.sv
// bound checks on the ex1 top level: reset state, stall freeze and idle slots
`timescale 1ns/1ns

module ex1StageAssertions (
	input logic            clock,
	input logic            arstN,
	input logic            memHold,
	input logic [5:0]      dOp,
	input ex1Pkg::gprId_t  regIdRn,
	input logic            braValid,
	input ex1Pkg::memOpm_t memOpm,
	input logic [15:0]     trapCode,
	input logic            srT
);
	import ex1Pkg::*;

	// two sampled reset cycles leave everything idle
	assert property (@(posedge clock) (!arstN ##1 !arstN) |->
		(regIdRn == GPR_ZZR && !braValid && memOpm == OPM_READY &&
		trapCode == TRAP_NONE && !srT))
		else $error("outputs not idle while reset is held");

	// a held cycle changes no control output
	assert property (@(posedge clock) disable iff (!arstN) memHold |=>
		($stable(regIdRn) && $stable(braValid) && $stable(memOpm) &&
		$stable(trapCode) && $stable(srT)))
		else $error("control outputs moved during memHold");

	// bubble in the stage register gives idle outputs and keeps T
	assert property (@(posedge clock) disable iff (!arstN)
		(!memHold && dOp == UCMD_NOP) |=>
		(regIdRn == GPR_ZZR && !braValid && memOpm == OPM_READY &&
		trapCode == TRAP_NONE && $stable(srT)))
		else $error("idle slot produced an active output");

endmodule

bind ex1Top ex1StageAssertions i_assertions (.*);

// File: hw/ex1Top.sv
// top of the ex1 execute pipeline: decode stage feeding the execute stage, two ops in flight
`timescale 1ns/1ns

module ex1Top #(
	parameter int addrW = ex1Pkg::ADDR_W_DEFAULT
) (
	input  logic              clock,
	input  logic              arstN,
	input  ex1Pkg::uCmd_t     opUCmd,
	input  ex1Pkg::uIxt_t     opUIxt,
	input  ex1Pkg::gprId_t    regIdRm,
	input  ex1Pkg::dataWord_t regValRs,
	input  ex1Pkg::dataWord_t regValRt,
	input  ex1Pkg::dataWord_t regValRm,
	input  ex1Pkg::dataWord_t regValPc,
	input  logic              opBraFlush,
	input  logic              memHold,
	output ex1Pkg::gprId_t    regIdRn,
	output ex1Pkg::dataWord_t regValRn,
	output logic              braValid,
	output ex1Pkg::dataWord_t braPc,
	output ex1Pkg::memOpm_t   memOpm,
	output logic [addrW-1:0]  memAddr,
	output ex1Pkg::dataWord_t memData,
	output logic [15:0]       trapCode,
	output logic              srT
);
	import ex1Pkg::*;

	// stage register between decode and execute
	logic [1:0]       dCond;
	logic [5:0]       dOp;
	uIxt_t            dIxt;
	gprId_t           dRm;
	dataWord_t        dRs;
	dataWord_t        dRt;
	dataWord_t        dRmVal;
	dataWord_t        dPc;
	logic [addrW-1:0] dAddr;
	logic             dInvalid;

	ex1Decode #(.addrW(addrW)) i_decode (
		.clock, .arstN, .memHold, .opBraFlush, .opUCmd, .opUIxt, .regIdRm,
		.regValRs, .regValRt, .regValRm, .regValPc,
		.dCond, .dOp, .dIxt, .dRm, .dRs, .dRt, .dRmVal, .dPc, .dAddr, .dInvalid
	);

	ex1Execute #(.addrW(addrW)) i_execute (
		.clock, .arstN, .memHold,
		.dCond, .dOp, .dIxt, .dRm, .dRs, .dRt, .dRmVal, .dPc, .dAddr, .dInvalid,
		.regIdRn, .regValRn, .braValid, .braPc, .memOpm, .memAddr, .memData,
		.trapCode, .srT
	);

endmodule

// File: ex1Exec/ex1Execute.sv
// second ex1 pipeline stage: predicates on SR.T, picks results, owns SR.T and registers outputs
`timescale 1ns/1ns

module ex1Execute #(
	parameter int addrW = ex1Pkg::ADDR_W_DEFAULT
) (
	input  logic              clock,
	input  logic              arstN,
	input  logic              memHold,
	input  logic [1:0]        dCond,
	input  logic [5:0]        dOp,
	input  ex1Pkg::uIxt_t     dIxt,
	input  ex1Pkg::gprId_t    dRm,
	input  ex1Pkg::dataWord_t dRs,
	input  ex1Pkg::dataWord_t dRt,
	input  ex1Pkg::dataWord_t dRmVal,
	input  ex1Pkg::dataWord_t dPc,
	input  logic [addrW-1:0]  dAddr,
	input  logic              dInvalid,
	output ex1Pkg::gprId_t    regIdRn,
	output ex1Pkg::dataWord_t regValRn,
	output logic              braValid,
	output ex1Pkg::dataWord_t braPc,
	output ex1Pkg::memOpm_t   memOpm,
	output logic [addrW-1:0]  memAddr,
	output ex1Pkg::dataWord_t memData,
	output logic [15:0]       trapCode,
	output logic              srT
);
	import ex1Pkg::*;

	logic      opEn;
	gprId_t    nIdRn;
	dataWord_t nValRn;
	logic      nBraValid;
	dataWord_t nBraPc;
	memOpm_t   nOpm;
	logic [15:0] nTrap;
	logic      nT;

	// predicate check against the current T
	always_comb begin
		case (dCond)
			CC_AL:   opEn = 1'b1;
			CC_CT:   opEn = srT;
			CC_CF:   opEn = !srT;
			// CC_NV never runs
			default: opEn = 1'b0;
		endcase
	end

	// result select, disabled op falls through as a NOP
	always_comb begin
		nIdRn     = GPR_ZZR;
		nValRn    = dRt;
		nBraValid = 1'b0;
		nBraPc    = dPc + (dRt << 1);
		nOpm      = OPM_READY;
		nTrap     = TRAP_NONE;
		nT        = srT;
		if (opEn) begin
			case (dOp)
				UCMD_LEA: begin
					nIdRn  = dRm;
					nValRn = dataWord_t'(dAddr);
				end
				UCMD_LOAD:  nOpm = {2'b01, dIxt.mem.sx, dIxt.mem.size};
				UCMD_STORE: nOpm = {2'b10, dIxt.mem.sx, dIxt.mem.size};
				UCMD_MOVIR: begin
					nIdRn = dRm;
					// shift-in forms keep the old Rs above the new bits
					case (dIxt.ctl.sub)
						IXT_LDISH8:  nValRn = {dRs[55:0], dRt[7:0]};
						IXT_LDISH16: nValRn = {dRs[47:0], dRt[15:0]};
						IXT_LDISH32: nValRn = {dRs[31:0], dRt[31:0]};
						default:     nValRn = dRt;
					endcase
				end
				// displacement is in 16-bit units
				UCMD_BRA: nBraValid = 1'b1;
				UCMD_JMP: begin
					nBraValid = 1'b1;
					nBraPc    = {dPc[63:48], dRs[47:0]};
				end
				UCMD_OPIXT: begin
					case (dIxt.ctl.sub)
						IXT_CLRT:  nT = 1'b0;
						IXT_SETT:  nT = 1'b1;
						IXT_NOTT:  nT = !srT;
						IXT_TRAPA: nTrap = TRAP_TRAPA_BASE | {12'h000, dRm[3:0]};
						default:   ;
					endcase
				end
				default: ;
			endcase
			// bad opcode from decode or an explicit INVOP
			if (dInvalid || (dOp == UCMD_INVOP))
				nTrap = TRAP_INVOP;
		end
	end

	// control outputs and SR.T, frozen while memory holds
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			regIdRn  <= GPR_ZZR;
			braValid <= 1'b0;
			memOpm   <= OPM_READY;
			trapCode <= TRAP_NONE;
			srT      <= 1'b0;
		end else if (!memHold) begin
			regIdRn  <= nIdRn;
			braValid <= nBraValid;
			memOpm   <= nOpm;
			trapCode <= nTrap;
			srT      <= nT;
		end
	end

	// data outputs, qualified by the control outputs above
	always_ff @(posedge clock) begin
		if (!memHold) begin
			regValRn <= nValRn;
			braPc    <= nBraPc;
			memAddr  <= dAddr;
			memData  <= dRmVal;
		end
	end

endmodule

// File: hw/ex1Decode.sv
// first ex1 pipeline stage: squashes flushed micro-ops, flags bad opcodes, registers the AGU result
`timescale 1ns/1ns

module ex1Decode #(
	parameter int addrW = ex1Pkg::ADDR_W_DEFAULT
) (
	input  logic              clock,
	input  logic              arstN,
	input  logic              memHold,
	input  logic              opBraFlush,
	input  ex1Pkg::uCmd_t     opUCmd,
	input  ex1Pkg::uIxt_t     opUIxt,
	input  ex1Pkg::gprId_t    regIdRm,
	input  ex1Pkg::dataWord_t regValRs,
	input  ex1Pkg::dataWord_t regValRt,
	input  ex1Pkg::dataWord_t regValRm,
	input  ex1Pkg::dataWord_t regValPc,
	output logic [1:0]        dCond,
	output logic [5:0]        dOp,
	output ex1Pkg::uIxt_t     dIxt,
	output ex1Pkg::gprId_t    dRm,
	output ex1Pkg::dataWord_t dRs,
	output ex1Pkg::dataWord_t dRt,
	output ex1Pkg::dataWord_t dRmVal,
	output ex1Pkg::dataWord_t dPc,
	output logic [addrW-1:0]  dAddr,
	output logic              dInvalid
);
	import ex1Pkg::*;

	logic [addrW-1:0] agAddr;
	logic             opKnown;

	// Rs is the base, Rt the index, mem.size the scale
	ex1AddrGen #(.addrW(addrW)) i_addrGen (
		.base  (regValRs),
		.index (regValRt),
		.scale (opUIxt.mem.size),
		.addr  (agAddr)
	);

	// opcode space is dense up to OPIXT
	assign opKnown = (opUCmd[5:0] <= UCMD_OPIXT);

	// control part of the stage register
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			dCond    <= CC_AL;
			dOp      <= UCMD_NOP;
			dInvalid <= 1'b0;
		end else if (!memHold) begin
			if (opBraFlush) begin
				// flushed op turns into a bubble
				dCond    <= CC_AL;
				dOp      <= UCMD_NOP;
				dInvalid <= 1'b0;
			end else if (!opKnown) begin
				// keep the condition, trap only if it would run
				dCond    <= opUCmd[7:6];
				dOp      <= UCMD_INVOP;
				dInvalid <= 1'b1;
			end else begin
				dCond    <= opUCmd[7:6];
				dOp      <= opUCmd[5:0];
				dInvalid <= 1'b0;
			end
		end
	end

	// operand capture, meaningless behind a NOP
	always_ff @(posedge clock) begin
		if (!memHold) begin
			dIxt   <= opUIxt;
			dRm    <= regIdRm;
			dRs    <= regValRs;
			dRt    <= regValRt;
			dRmVal <= regValRm;
			dPc    <= regValPc;
			dAddr  <= agAddr;
		end
	end

endmodule

// File: hw/ex1AddrGen.sv
// address generator for the ex1 decode stage: base plus index scaled by access size
`timescale 1ns/1ns

module ex1AddrGen #(
	parameter int addrW = ex1Pkg::ADDR_W_DEFAULT
) (
	input  ex1Pkg::dataWord_t base,
	input  ex1Pkg::dataWord_t index,
	input  logic [1:0]        scale,
	output logic [addrW-1:0]  addr
);
	import ex1Pkg::*;

	dataWord_t scaledIdx;
	dataWord_t sum;

	// scale 0..3 gives x1, x2, x4, x8
	assign scaledIdx = index << scale;

	// full-width add, carry past bit 63 is dropped
	assign sum = base + scaledIdx;

	// only the virtual address bits leave
	assign addr = sum[addrW-1:0];

endmodule

// File: common/ex1Pkg.sv
// shared widths, micro-op encodings and trap codes for the ex1 pipeline; imported by each stage
package ex1Pkg;

	// register word and default virtual address width
	localparam int DATA_W         = 64;
	localparam int ADDR_W_DEFAULT = 48;

	typedef logic [DATA_W-1:0] dataWord_t;

	// register number, zero register means no write
	typedef logic [4:0] gprId_t;
	localparam gprId_t GPR_ZZR = 5'd0;

	// micro-command: [7:6] condition, [5:0] opcode, bit 8 spare
	typedef logic [8:0] uCmd_t;

	// condition codes, tested against SR.T
	localparam logic [1:0] CC_AL = 2'd0;
	localparam logic [1:0] CC_NV = 2'd1;
	localparam logic [1:0] CC_CT = 2'd2;
	localparam logic [1:0] CC_CF = 2'd3;

	// opcodes, dense from zero so decode can range-check
	localparam logic [5:0] UCMD_NOP   = 6'h00;
	localparam logic [5:0] UCMD_INVOP = 6'h01;
	localparam logic [5:0] UCMD_LEA   = 6'h02;
	localparam logic [5:0] UCMD_STORE = 6'h03;
	localparam logic [5:0] UCMD_LOAD  = 6'h04;
	localparam logic [5:0] UCMD_MOVIR = 6'h05;
	localparam logic [5:0] UCMD_BRA   = 6'h06;
	localparam logic [5:0] UCMD_JMP   = 6'h07;
	localparam logic [5:0] UCMD_OPIXT = 6'h08;

	// extension word, read as memory fields or as a control sub-opcode
	typedef union packed {
		struct packed {
			logic [5:0] unused;
			logic       sx;
			// byte/word/long/quad, doubles as index scale
			logic [1:0] size;
		} mem;
		struct packed {
			logic [2:0] unused;
			logic [5:0] sub;
		} ctl;
	} uIxt_t;

	// immediate shift-in kinds for MOVIR
	localparam logic [5:0] IXT_LDI     = 6'h00;
	localparam logic [5:0] IXT_LDISH8  = 6'h01;
	localparam logic [5:0] IXT_LDISH16 = 6'h02;
	localparam logic [5:0] IXT_LDISH32 = 6'h03;

	// SR operations for OPIXT
	localparam logic [5:0] IXT_CLRT  = 6'h10;
	localparam logic [5:0] IXT_SETT  = 6'h11;
	localparam logic [5:0] IXT_NOTT  = 6'h12;
	localparam logic [5:0] IXT_TRAPA = 6'h13;

	// memory op: 01 load or 10 store, then sign and size
	typedef logic [4:0] memOpm_t;
	localparam memOpm_t OPM_READY = 5'b00000;

	// trap codes, TRAPA ors in the low bits of Rm
	localparam logic [15:0] TRAP_NONE       = 16'h0000;
	localparam logic [15:0] TRAP_INVOP      = 16'h800E;
	localparam logic [15:0] TRAP_TRAPA_BASE = 16'hC080;

endpackage
